// ==== flist.f ====
source/mipsPkg.sv
source/pipeIfs.sv
source/controller.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/mipsTop.sv
testbench/tbMips.sv

// ==== run.sh ====
#!/bin/sh
# builds tbMips with Verilator and runs it; the exit status is the simulation result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tbMips -f flist.f \
	--Mdir obj_dir -o simTbMips
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/simTbMips
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished with status 0"
exit 0

// ==== source/controller.sv ====
// decode-stage control for add/sub/and/or/slt, lw, sw, beq, addi, j
// anything else, including an unknown R-type funct, decodes to an all-zero nop
module controller (
	input  mipsPkg::opcodeE op,
	input  mipsPkg::functE  funct,
	output mipsPkg::ctrlS   ctrl
);
	import mipsPkg::*;

	logic [1:0] aluOp;   // 00 add, 01 sub, 10 from funct
	ctrlS       mainCtrl; // main decoder output, aluCtrl left at zero
	aluCtrlE    aluCtrl;
	logic       aluOk;   // aluOp/funct pair is legal

	// main decoder
	always_comb begin
		mainCtrl = '0;
		aluOp = 2'b00;
		case (op)
			OP_RTYPE: begin
				mainCtrl.regWrite = 1'b1;
				mainCtrl.regDst = 1'b1;
				aluOp = 2'b10;
			end
			OP_LW: begin
				mainCtrl.regWrite = 1'b1;
				mainCtrl.aluSrc = 1'b1;
				mainCtrl.memToReg = 1'b1;
			end
			OP_SW: begin
				mainCtrl.aluSrc = 1'b1;
				mainCtrl.memWrite = 1'b1;
			end
			OP_BEQ: begin
				mainCtrl.branch = 1'b1;
				aluOp = 2'b01; // compare happens in decode, sub kept for symmetry
			end
			OP_ADDI: begin
				mainCtrl.regWrite = 1'b1;
				mainCtrl.aluSrc = 1'b1;
			end
			OP_J:    mainCtrl.jump = 1'b1;
			default: mainCtrl = '0; // illegal op
		endcase
	end

	// alu decoder
	always_comb begin
		aluCtrl = ALU_AND;
		aluOk = 1'b1;
		case (aluOp)
			2'b00: aluCtrl = ALU_ADD; // lw, sw, addi
			2'b01: aluCtrl = ALU_SUB; // beq
			2'b10: begin
				case (funct)
					FN_ADD:  aluCtrl = ALU_ADD;
					FN_SUB:  aluCtrl = ALU_SUB;
					FN_AND:  aluCtrl = ALU_AND;
					FN_OR:   aluCtrl = ALU_OR;
					FN_SLT:  aluCtrl = ALU_SLT;
					default: aluOk = 1'b0;
				endcase
			end
			default: aluOk = 1'b0;
		endcase
	end

	always_comb begin
		ctrl = mainCtrl;
		ctrl.aluCtrl = aluCtrl;
		if (!aluOk) ctrl = '0; // bad funct kills the whole word
	end

endmodule : controller

// ==== source/decodeStage.sv ====
// register file, early beq compare and ID/EX register; also the writeback point
// regfile writes on the falling edge so a same-cycle read sees the new value
module decodeStage (
	input  logic            clk,
	input  logic            arstN,
	input  mipsPkg::instrU  instrD,
	input  logic [31:0]     pcPlus4D,
	input  logic            forwardAD,
	input  logic            forwardBD,
	input  logic            flushE,
	input  logic            stallE,
	idExIf.source           idEx,
	memWbIf.sink            wb,
	input  logic [31:0]     exAluOut,  // memory-stage alu result for the compare
	output mipsPkg::regIdxT rsD,
	output mipsPkg::regIdxT rtD,
	output logic            pcSrcD,
	output logic            jumpD,
	output logic [31:0]     branchTargetD,
	output logic [31:0]     jumpTargetD,
	output logic [31:0]     resultW    // writeback value, also forwarded into execute
);
	import mipsPkg::*;

	logic [31:0] regs [32];
	logic [31:0] rd1D;
	logic [31:0] rd2D;
	logic [31:0] srcAD;
	logic [31:0] srcBD;
	logic [31:0] signImmD;
	logic        equalD;
	ctrlS        ctrlD;

	controller uCtrl (
		.op   (instrD.rFields.op),
		.funct(instrD.rFields.funct),
		.ctrl (ctrlD)
	);

	assign resultW = wb.memToReg ? wb.readData : wb.aluOut;

	always_ff @(negedge clk) begin
		if (wb.regWrite && wb.writeReg != 5'd0) regs[wb.writeReg] <= resultW;
	end

	assign rsD = instrD.rFields.rs;
	assign rtD = instrD.rFields.rt;
	assign rd1D = (rsD == 5'd0) ? 32'd0 : regs[rsD]; // $0 reads zero
	assign rd2D = (rtD == 5'd0) ? 32'd0 : regs[rtD];

	// beq resolved here
	assign srcAD = forwardAD ? exAluOut : rd1D;
	assign srcBD = forwardBD ? exAluOut : rd2D;
	assign equalD = (srcAD == srcBD);
	assign pcSrcD = ctrlD.branch & equalD;
	assign jumpD = ctrlD.jump;

	assign signImmD = {{16{instrD.iFields.imm[15]}}, instrD.iFields.imm};
	assign branchTargetD = pcPlus4D + {signImmD[29:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[31:28], instrD.jFields.target, 2'b00};

	// ID/EX control and indices, bubble on flush
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx.ctrl <= '0;
			idEx.rs <= '0;
			idEx.rt <= '0;
			idEx.rd <= '0;
		end else if (flushE) begin
			idEx.ctrl <= '0;
			idEx.rs <= '0;
			idEx.rt <= '0;
			idEx.rd <= '0;
		end else if (!stallE) begin
			idEx.ctrl <= ctrlD;
			idEx.rs <= rsD;
			idEx.rt <= rtD;
			idEx.rd <= instrD.rFields.rd;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallE) begin
			idEx.rd1 <= rd1D;
			idEx.rd2 <= rd2D;
			idEx.signImm <= signImmD;
		end
	end

endmodule : decodeStage

// ==== source/executeStage.sv ====
// forwarding muxes, alu and EX/MEM register; no overflow trap on add/sub
module executeStage (
	input  logic        clk,
	input  logic        arstN,
	input  logic        stallE,
	input  logic [1:0]  forwardAE, // 00 regfile, 01 writeback, 10 memory
	input  logic [1:0]  forwardBE,
	idExIf.sink         idEx,
	exMemIf.source      exMem,
	input  logic [31:0] resultW
);
	import mipsPkg::*;

	logic [31:0] srcAE;
	logic [31:0] writeDataE; // rt after forwarding, store data
	logic [31:0] srcBE;
	logic [31:0] aluOutE;
	regIdxT      writeRegE;

	always_comb begin
		case (forwardAE)
			2'b01:   srcAE = resultW;
			2'b10:   srcAE = exMem.aluOut;
			default: srcAE = idEx.rd1;
		endcase
		case (forwardBE)
			2'b01:   writeDataE = resultW;
			2'b10:   writeDataE = exMem.aluOut;
			default: writeDataE = idEx.rd2;
		endcase
	end

	assign srcBE = idEx.ctrl.aluSrc ? idEx.signImm : writeDataE;
	assign writeRegE = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	always_comb begin
		case (idEx.ctrl.aluCtrl)
			ALU_AND: aluOutE = srcAE & srcBE;
			ALU_OR:  aluOutE = srcAE | srcBE;
			ALU_ADD: aluOutE = srcAE + srcBE;
			ALU_SUB: aluOutE = srcAE - srcBE;
			ALU_SLT: aluOutE = {31'd0, $signed(srcAE) < $signed(srcBE)}; // signed compare
			default: aluOutE = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exMem.regWrite <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
			exMem.writeReg <= '0;
		end else if (!stallE) begin
			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.memToReg <= idEx.ctrl.memToReg;
			exMem.writeReg <= writeRegE;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallE) begin
			exMem.aluOut <= aluOutE;
			exMem.writeData <= writeDataE;
		end
	end

endmodule : executeStage

// ==== source/fetchStage.sv ====
// pc register and IF/ID register; no delay slot, a taken branch or jump squashes IF/ID
module fetchStage #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        arstN,
	input  logic        stallF,
	input  logic        stallD,
	input  logic        pcSrcD,
	input  logic        jumpD,
	input  logic [31:0] branchTargetD,
	input  logic [31:0] jumpTargetD,
	output logic [31:0] imemAddr,
	input  logic [31:0] imemData,
	output logic [31:0] instrD,
	output logic [31:0] pcPlus4D
);
	logic [31:0] pcF;
	logic [31:0] pcPlus4F;
	logic [31:0] pcNext;

	assign imemAddr = pcF; // combinational read, instr back same cycle
	assign pcPlus4F = pcF + 32'd4;
	assign pcNext = jumpD ? jumpTargetD : (pcSrcD ? branchTargetD : pcPlus4F);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) pcF <= resetPc;
		else if (!stallF) pcF <= pcNext;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) instrD <= '0; // all zero word decodes as nop
		else if (!stallD) instrD <= (pcSrcD || jumpD) ? '0 : imemData;
	end

	always_ff @(posedge clk) begin
		if (!stallD) pcPlus4D <= pcPlus4F;
	end

endmodule : fetchStage

// ==== source/hazardUnit.sv ====
// forwarding selects, load-use and branch stalls, and the memory freeze
// branch operands forward only from memory; anything newer stalls decode
module hazardUnit (
	input  mipsPkg::regIdxT rsD,
	input  mipsPkg::regIdxT rtD,
	idExIf.monitor          idEx,
	exMemIf.monitor         exMem,
	memWbIf.monitor         memWb,
	input  logic            memBusy,
	output logic            stallF,
	output logic            stallD,
	output logic            stallE,
	output logic            flushE,
	output logic            forwardAD,
	output logic            forwardBD,
	output logic [1:0]      forwardAE,
	output logic [1:0]      forwardBE
);
	import mipsPkg::*;

	regIdxT writeRegE;
	logic   lwStall;
	logic   branchStall;
	logic   hazStall;

	assign writeRegE = idEx.ctrl.regDst ? idEx.rd : idEx.rt; // same pick as execute

	// execute forwarding, memory wins over writeback
	always_comb begin
		forwardAE = 2'b00;
		forwardBE = 2'b00;
		if (idEx.rs != 5'd0 && exMem.regWrite && idEx.rs == exMem.writeReg) forwardAE = 2'b10;
		else if (idEx.rs != 5'd0 && memWb.regWrite && idEx.rs == memWb.writeReg) forwardAE = 2'b01;
		if (idEx.rt != 5'd0 && exMem.regWrite && idEx.rt == exMem.writeReg) forwardBE = 2'b10;
		else if (idEx.rt != 5'd0 && memWb.regWrite && idEx.rt == memWb.writeReg) forwardBE = 2'b01;
	end

	assign forwardAD = (rsD != 5'd0) && exMem.regWrite && (rsD == exMem.writeReg);
	assign forwardBD = (rtD != 5'd0) && exMem.regWrite && (rtD == exMem.writeReg);

	assign lwStall = idEx.ctrl.memToReg && (idEx.rt == rsD || idEx.rt == rtD);
	// decode reads of a result still in execute, or of a load in memory, wait
	assign branchStall = (idEx.ctrl.regWrite && writeRegE != 5'd0
		&& (writeRegE == rsD || writeRegE == rtD))
		|| (exMem.memToReg && (exMem.writeReg == rsD || exMem.writeReg == rtD));
	assign hazStall = lwStall | branchStall;

	assign stallF = hazStall | memBusy;
	assign stallD = hazStall | memBusy;
	assign stallE = memBusy;              // whole pipe freezes on a data access
	assign flushE = hazStall & ~memBusy;  // never squash an instruction that is frozen

endmodule : hazardUnit

// ==== source/memoryStage.sv ====
// four-phase req/ack master for lw/sw and MEM/WB register
// word accesses only; address, we and wdata come straight from EX/MEM and hold while busy
module memoryStage (
	input  logic        clk,
	input  logic        arstN,
	exMemIf.sink        exMem,
	memWbIf.source      memWb,
	output logic        dmemReq,
	output logic        dmemWe,
	output logic [31:0] dmemAddr,
	output logic [31:0] dmemWdata,
	input  logic        dmemAck,
	input  logic [31:0] dmemRdata,
	output logic        memBusy
);
	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stReq  = 2'd1; // req high, waiting for ack
	localparam logic [1:0] stRel  = 2'd2; // req dropped, waiting for ack low
	localparam logic [1:0] stDone = 2'd3; // one cycle to let the pipe advance

	logic [1:0]  state;
	logic [1:0]  stateNext;
	logic        memOp;
	logic [31:0] rdLatch;

	assign memOp = exMem.memWrite | exMem.memToReg;

	always_comb begin
		stateNext = state;
		case (state)
			stIdle: if (memOp) stateNext = stReq;
			stReq:  if (dmemAck) stateNext = stRel;
			stRel:  if (!dmemAck) stateNext = stDone;
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) state <= stIdle;
		else state <= stateNext;
	end

	assign dmemReq = (state == stReq);
	assign dmemWe = exMem.memWrite;
	assign dmemAddr = exMem.aluOut;
	assign dmemWdata = exMem.writeData;
	assign memBusy = memOp && (state != stDone);

	always_ff @(posedge clk) begin
		if (state == stReq && dmemAck) rdLatch <= dmemRdata; // valid while ack high
	end

	// WB keeps its instruction while busy so forwarding into a frozen execute stays right
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memWb.regWrite <= 1'b0;
			memWb.memToReg <= 1'b0;
			memWb.writeReg <= '0;
		end else if (!memBusy) begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.writeReg <= exMem.writeReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!memBusy) begin
			memWb.aluOut <= exMem.aluOut;
			memWb.readData <= rdLatch;
		end
	end

endmodule : memoryStage

// ==== source/mipsPkg.sv ====
// shared encodings and types for the five-stage core
// illegal opcode/funct values can still sit in the enum fields; the controller treats them as nop
package mipsPkg;

	typedef logic [4:0] regIdxT; // register file index

	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011,
		OP_BEQ   = 6'b000100,
		OP_ADDI  = 6'b001000,
		OP_J     = 6'b000010
	} opcodeE;

	typedef enum logic [5:0] {
		FN_ADD = 6'b100000,
		FN_SUB = 6'b100010,
		FN_AND = 6'b100100,
		FN_OR  = 6'b100101,
		FN_SLT = 6'b101010
	} functE;

	typedef enum logic [2:0] {
		ALU_AND = 3'b000,
		ALU_OR  = 3'b001,
		ALU_ADD = 3'b010,
		ALU_SUB = 3'b110,
		ALU_SLT = 3'b111
	} aluCtrlE;

	typedef struct packed {
		opcodeE     op;
		regIdxT     rs;
		regIdxT     rt;
		regIdxT     rd;
		logic [4:0] shamt; // no shifts decoded
		functE      funct;
	} rFieldsT;

	typedef struct packed {
		opcodeE      op;
		regIdxT      rs;
		regIdxT      rt;
		logic [15:0] imm;
	} iFieldsT;

	typedef struct packed {
		opcodeE      op;
		logic [25:0] target; // word address within the 256MB region
	} jFieldsT;

	typedef union packed {
		rFieldsT rFields;
		iFieldsT iFields;
		jFieldsT jFields;
	} instrU;

	// all zero is a bubble
	typedef struct packed {
		logic    regWrite;
		logic    regDst;   // 1 selects rd, 0 selects rt
		logic    aluSrc;   // 1 selects the immediate
		logic    branch;
		logic    memWrite;
		logic    memToReg;
		logic    jump;
		aluCtrlE aluCtrl;
	} ctrlS;

endpackage : mipsPkg

// ==== source/mipsTop.sv ====
// five-stage MIPS subset core; instruction memory read is combinational
// data memory uses a four-phase req/ack handshake with one access in flight
module mipsTop #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        arstN,
	output logic [31:0] imemAddr,
	input  logic [31:0] imemData,
	output logic        dmemReq,
	output logic        dmemWe,
	output logic [31:0] dmemAddr,
	output logic [31:0] dmemWdata,
	input  logic        dmemAck,
	input  logic [31:0] dmemRdata
);
	import mipsPkg::*;

	logic [31:0] instrD;
	logic [31:0] pcPlus4D;
	logic [31:0] branchTargetD;
	logic [31:0] jumpTargetD;
	logic [31:0] resultW;
	logic        pcSrcD;
	logic        jumpD;
	regIdxT      rsD;
	regIdxT      rtD;
	logic        stallF;
	logic        stallD;
	logic        stallE;
	logic        flushE;
	logic        forwardAD;
	logic        forwardBD;
	logic [1:0]  forwardAE;
	logic [1:0]  forwardBE;
	logic        memBusy;

	idExIf  idEx ();
	exMemIf exMem ();
	memWbIf memWb ();

	fetchStage #(.resetPc(resetPc)) uFetch (
		.clk(clk), .arstN(arstN), .stallF(stallF), .stallD(stallD),
		.pcSrcD(pcSrcD), .jumpD(jumpD),
		.branchTargetD(branchTargetD), .jumpTargetD(jumpTargetD),
		.imemAddr(imemAddr), .imemData(imemData),
		.instrD(instrD), .pcPlus4D(pcPlus4D)
	);

	decodeStage uDecode (
		.clk(clk), .arstN(arstN), .instrD(instrD), .pcPlus4D(pcPlus4D),
		.forwardAD(forwardAD), .forwardBD(forwardBD), .flushE(flushE), .stallE(stallE),
		.idEx(idEx.source), .wb(memWb.sink), .exAluOut(exMem.aluOut),
		.rsD(rsD), .rtD(rtD), .pcSrcD(pcSrcD), .jumpD(jumpD),
		.branchTargetD(branchTargetD), .jumpTargetD(jumpTargetD), .resultW(resultW)
	);

	executeStage uExecute (
		.clk(clk), .arstN(arstN), .stallE(stallE),
		.forwardAE(forwardAE), .forwardBE(forwardBE),
		.idEx(idEx.sink), .exMem(exMem.source), .resultW(resultW)
	);

	memoryStage uMemory (
		.clk(clk), .arstN(arstN), .exMem(exMem.sink), .memWb(memWb.source),
		.dmemReq(dmemReq), .dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
		.dmemAck(dmemAck), .dmemRdata(dmemRdata), .memBusy(memBusy)
	);

	hazardUnit uHazard (
		.rsD(rsD), .rtD(rtD),
		.idEx(idEx.monitor), .exMem(exMem.monitor), .memWb(memWb.monitor),
		.memBusy(memBusy),
		.stallF(stallF), .stallD(stallD), .stallE(stallE), .flushE(flushE),
		.forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE)
	);

endmodule : mipsTop

// ==== source/pipeIfs.sv ====
// pipeline register bundles; the writing stage owns the flops behind each one
// monitor modports are read-only taps for the hazard unit

interface idExIf;
	import mipsPkg::*;

	ctrlS        ctrl;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] signImm;
	regIdxT      rs;
	regIdxT      rt;
	regIdxT      rd;

	modport source (output ctrl, rd1, rd2, signImm, rs, rt, rd);
	modport sink (input ctrl, rd1, rd2, signImm, rs, rt, rd);
	modport monitor (input ctrl, rs, rt, rd); // dest select redone in hazard unit
endinterface : idExIf

interface exMemIf;
	import mipsPkg::*;

	logic        regWrite;
	logic        memWrite;
	logic        memToReg;
	logic [31:0] aluOut;    // also the data memory address
	logic [31:0] writeData; // store data
	regIdxT      writeReg;

	modport source (output regWrite, memWrite, memToReg, aluOut, writeData, writeReg);
	modport sink (input regWrite, memWrite, memToReg, aluOut, writeData, writeReg);
	modport monitor (input regWrite, memToReg, writeReg);
endinterface : exMemIf

interface memWbIf;
	import mipsPkg::*;

	logic        regWrite;
	logic        memToReg;
	logic [31:0] aluOut;
	logic [31:0] readData;
	regIdxT      writeReg;

	modport source (output regWrite, memToReg, aluOut, readData, writeReg);
	modport sink (input regWrite, memToReg, aluOut, readData, writeReg);
	modport monitor (input regWrite, writeReg);
endinterface : memWbIf

// ==== testbench/tbMips.sv ====
// testbench for mipsTop: program image in an array, req/ack data memory with random latency
// expected loads, stores and branch targets come from a sequential ISA model run before reset
// data memory covers 64 words from address 0, any access outside it fails the run
module tbMips;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] resetPc = 32'h0000_0100;
	localparam int progLen = 34;
	localparam logic [31:0] haltPc = resetPc + 32'd4 * (progLen - 1); // j to itself
	localparam int memWords = 64;
	localparam int maxCycles = 40 * progLen * 10; // worst-case memory delay per instruction

	// ISA encodings for the assembler helpers and the model
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	logic        clk;
	logic        arstN;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic        dmemReq;
	logic        dmemWe;
	logic [31:0] dmemAddr;
	logic [31:0] dmemWdata;
	logic        dmemAck;
	logic [31:0] dmemRdata;

	logic [31:0] prog [progLen];
	logic [31:0] progIdx;
	logic [31:0] dmem [memWords];
	logic [31:0] modelMem [memWords];
	logic [31:0] modelReg [32];
	logic [31:0] expStAddr [$];
	logic [31:0] expStData [$];
	logic [31:0] expLdAddr [$];
	logic [31:0] expTargets [$]; // fetch targets of taken beq and j, in order
	logic [31:0] expBranchPc [$]; // fetch address of each of those beq and j
	int          storeCount = 0;
	int          loadCount = 0;
	int          targetIdx = 0;
	int          seed = 32'hf9a3_7eca;
	logic        prevReq;
	logic        prevAck;
	logic        prevWe;
	logic [31:0] prevAddr;
	logic [31:0] prevWdata;
	logic [31:0] fetchLast = resetPc; // last two distinct fetch addresses
	logic [31:0] fetchPrev = '1;

	mipsTop #(.resetPc(resetPc)) dut (
		.clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
		.dmemReq(dmemReq), .dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
		.dmemAck(dmemAck), .dmemRdata(dmemRdata)
	);

	task automatic stopOnFailure();
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at the first failing check");
	endtask

	task automatic valueMismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
		stopOnFailure();
	endtask

	task automatic plainFailure(input string what);
		$display("** Error: %s", what);
		stopOnFailure();
	endtask

	// assembler helpers, operands in asm order
	function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		return {opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeJ(input int idx);
		logic [31:0] target;
		target = resetPc + 32'd4 * idx;
		return {opJ, target[27:2]};
	endfunction

	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h3c5a_96e1; // odd multiplier mixes every address bit
	endfunction

	task automatic loadProgram();
		prog[0] = encodeI(opAddi, 5'd1, 5'd0, 16'd5);
		prog[1] = encodeI(opAddi, 5'd2, 5'd0, 16'hfffd); // -3
		prog[2] = encodeR(fnAdd, 5'd3, 5'd1, 5'd2);      // dependent chain starts
		prog[3] = encodeR(fnSub, 5'd4, 5'd3, 5'd1);
		prog[4] = encodeR(fnAnd, 5'd5, 5'd4, 5'd1);
		prog[5] = encodeR(fnOr, 5'd6, 5'd5, 5'd2);
		prog[6] = encodeR(fnSlt, 5'd7, 5'd2, 5'd1);
		prog[7] = encodeI(opSw, 5'd3, 5'd0, 16'h0080);
		prog[8] = encodeI(opSw, 5'd4, 5'd0, 16'h0084);
		prog[9] = encodeI(opSw, 5'd5, 5'd0, 16'h0088);
		prog[10] = encodeI(opSw, 5'd6, 5'd0, 16'h008c);
		prog[11] = encodeI(opSw, 5'd7, 5'd0, 16'h0090);
		prog[12] = encodeI(opLw, 5'd8, 5'd0, 16'h0010);
		prog[13] = encodeR(fnAdd, 5'd9, 5'd8, 5'd1);     // load-use
		prog[14] = encodeI(opSw, 5'd9, 5'd0, 16'h0094);
		prog[15] = encodeI(opLw, 5'd13, 5'd0, 16'h0014);
		prog[16] = encodeI(opLw, 5'd10, 5'd0, 16'h0014);
		prog[17] = encodeI(opBeq, 5'd13, 5'd10, 16'd1);  // branch on just-loaded value, taken
		prog[18] = encodeI(opSw, 5'd10, 5'd0, 16'h0098); // skipped
		prog[19] = encodeI(opSw, 5'd10, 5'd0, 16'h009c);
		prog[20] = encodeI(opBeq, 5'd1, 5'd1, 16'd2);    // taken
		prog[21] = encodeI(opSw, 5'd1, 5'd0, 16'h00a0);  // skipped
		prog[22] = encodeI(opSw, 5'd2, 5'd0, 16'h00a4);  // skipped
		prog[23] = encodeI(opBeq, 5'd2, 5'd1, 16'd5);    // not taken
		prog[24] = encodeJ(27);
		prog[25] = encodeI(opSw, 5'd1, 5'd0, 16'h00a8);  // skipped
		prog[26] = encodeI(opAddi, 5'd7, 5'd0, 16'd99);  // skipped
		prog[27] = {6'h3f, 5'd1, 5'd7, 16'h0063};        // illegal opcode aimed at r7
		prog[28] = encodeI(opSw, 5'd7, 5'd0, 16'h00ac);
		prog[29] = encodeR(fnSlt, 5'd11, 5'd1, 5'd2);
		prog[30] = encodeI(opAddi, 5'd12, 5'd11, 16'd7);
		prog[31] = encodeI(opSw, 5'd12, 5'd0, 16'h00b0);
		prog[32] = encodeI(opSw, 5'd11, 5'd0, 16'h00b4);
		prog[33] = encodeJ(33); // halt loop
		for (int i = 0; i < memWords; i++) begin
			dmem[i] = fillWord(32'(i * 4));
			modelMem[i] = fillWord(32'(i * 4));
		end
	endtask

	// sequential ISA model, no delay slot, illegal ops do nothing
	task automatic buildExpected();
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic        legal;
		int          steps;
		for (int i = 0; i < 32; i++) modelReg[i] = '0;
		pc = resetPc;
		steps = 0;
		while (pc != haltPc && steps < 1000) begin
			ins = prog[(pc - resetPc) >> 2];
			a = modelReg[ins[25:21]];
			b = modelReg[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			pc = pc + 32'd4;
			case (ins[31:26])
				opRType: begin
					legal = 1'b1;
					case (ins[5:0])
						fnAdd:   res = a + b;
						fnSub:   res = a - b;
						fnAnd:   res = a & b;
						fnOr:    res = a | b;
						fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: legal = 1'b0;
					endcase
					if (legal && ins[15:11] != 5'd0) modelReg[ins[15:11]] = res;
				end
				opLw: begin
					expLdAddr.push_back(a + imm);
					if (ins[20:16] != 5'd0) modelReg[ins[20:16]] = modelMem[(a + imm) >> 2];
				end
				opSw: begin
					expStAddr.push_back(a + imm);
					expStData.push_back(b);
					modelMem[(a + imm) >> 2] = b;
				end
				opBeq: if (a == b) begin
					expBranchPc.push_back(pc - 32'd4);
					pc = pc + (imm << 2);
					expTargets.push_back(pc);
				end
				opAddi: if (ins[20:16] != 5'd0) modelReg[ins[20:16]] = a + imm;
				opJ: begin
					expBranchPc.push_back(pc - 32'd4);
					pc = {pc[31:28], ins[25:0], 2'b00};
					expTargets.push_back(pc);
				end
				default: ; // illegal opcode
			endcase
			steps++;
		end
		assert (pc == haltPc) else plainFailure("reference model never reached the halt loop");
	endtask

	task automatic checkResetState();
		assert (!dmemReq) else plainFailure("dmemReq high during or right after reset");
		assert (imemAddr == resetPc) else valueMismatch("imemAddr", imemAddr, resetPc);
	endtask

	// one data access, sampled while dmemReq is high and stable
	task automatic serveAccess();
		logic [31:0] addr;
		addr = dmemAddr;
		assert (addr < memWords * 4 && addr[1:0] == 2'b00)
			else plainFailure("data access outside the modeled memory or unaligned");
		if (dmemWe) begin
			assert (storeCount < expStAddr.size())
				else plainFailure("store issued beyond the model's store list");
			assert (addr == expStAddr[storeCount])
				else valueMismatch("dmemAddr", addr, expStAddr[storeCount]);
			assert (dmemWdata == expStData[storeCount])
				else valueMismatch("dmemWdata", dmemWdata, expStData[storeCount]);
			dmem[addr[7:2]] = dmemWdata;
			storeCount++;
		end else begin
			assert (loadCount < expLdAddr.size())
				else plainFailure("load issued beyond the model's load list");
			assert (addr == expLdAddr[loadCount])
				else valueMismatch("dmemAddr", addr, expLdAddr[loadCount]);
			dmemRdata = dmem[addr[7:2]];
			loadCount++;
		end
	endtask

	always_comb begin
		progIdx = (imemAddr - resetPc) >> 2;
		if (imemAddr >= resetPc && progIdx < progLen) imemData = prog[progIdx[5:0]];
		else imemData = 32'h0; // nop outside the image
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// data memory, 0..5 cycles to ack, 0..3 cycles to release
	initial begin : dataMemory
		int delay;
		dmemAck = 1'b0;
		dmemRdata = '0;
		forever begin
			@(posedge clk);
			#0.5;
			if (dmemReq && !dmemAck) begin
				delay = $unsigned($random(seed)) % 6;
				repeat (delay) begin
					@(posedge clk);
					#0.5;
				end
				serveAccess();
				dmemAck = 1'b1;
				while (dmemReq) begin
					@(posedge clk);
					#0.5;
				end
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) begin
					@(posedge clk);
					#0.5;
				end
				dmemAck = 1'b0;
			end
		end
	end

	// handshake rules and fetch redirects, sampled mid-cycle
	always @(negedge clk) begin
		if (arstN) begin
			if (prevReq && !prevAck) begin
				assert (dmemReq) else plainFailure("dmemReq dropped before dmemAck rose");
				assert (dmemAddr == prevAddr) else valueMismatch("dmemAddr", dmemAddr, prevAddr);
				assert (dmemWe == prevWe) else valueMismatch("dmemWe", 32'(dmemWe), 32'(prevWe));
				assert (dmemWdata == prevWdata)
					else valueMismatch("dmemWdata", dmemWdata, prevWdata);
			end
			if (dmemReq && !prevReq) begin
				assert (!prevAck) else plainFailure("dmemReq rose again while dmemAck was high");
			end
			// after a taken beq or j, one flushed slot, then the target
			if (imemAddr != fetchLast) begin
				if (targetIdx < expTargets.size()
					&& fetchPrev == expBranchPc[targetIdx]) begin
					assert (imemAddr == expTargets[targetIdx])
						else valueMismatch("imemAddr", imemAddr, expTargets[targetIdx]);
					targetIdx++;
				end
				fetchPrev = fetchLast;
				fetchLast = imemAddr;
			end
		end
		prevReq = dmemReq;
		prevAck = dmemAck;
		prevWe = dmemWe;
		prevAddr = dmemAddr;
		prevWdata = dmemWdata;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > maxCycles) plainFailure("timeout, program did not reach its end");
		end
	end

	initial begin : mainFlow
		arstN = 1'b0;
		loadProgram();
		buildExpected();
		repeat (16) begin
			@(negedge clk);
			checkResetState();
		end
		@(posedge clk);
		#0.5;
		arstN = 1'b1;
		@(negedge clk);
		checkResetState(); // pc not yet advanced
		// end of program: halt fetched, all stores seen, bus quiet
		do begin
			@(negedge clk);
		end while (!(imemAddr == haltPc && storeCount == expStAddr.size() && !dmemReq
			&& !dmemAck));
		assert (loadCount == expLdAddr.size())
			else valueMismatch("loadCount", 32'(loadCount), 32'(expLdAddr.size()));
		assert (targetIdx == expTargets.size())
			else plainFailure("fetch never reached every taken branch or jump target");
		for (int i = 0; i < memWords; i++) begin
			assert (dmem[i] == modelMem[i])
				else valueMismatch($sformatf("dmem[0x%0h]", i * 4), dmem[i], modelMem[i]);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule : tbMips
